/* sources.f */
design/periph_pkg.sv
design/reg_decode.sv
design/timer_bank.sv
design/irq_ctrl.sv
design/resp_mux.sv
design/periph_top.sv
verif/periph_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it; exit status is the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module periph_tb \
    -o periph_sim

./obj_dir/periph_sim

/* verif/periph_tb.sv */
// fixed config of two timers and two targets; LFSR-driven random traffic, stops at first mismatch
module periph_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import periph_pkg::*;

    localparam int TimerCnt    = 2;
    localparam int NumTargets  = 2;
    localparam int NumSrc      = 1 + TimerCnt;
    localparam int ResetCycles = 8;
    localparam int StimCycles  = 2500;
    localparam int MaxCycles   = StimCycles + 500;
    localparam logic [31:0] LfsrSeed = 32'hbfef7506;
    localparam logic [31:0] LfsrTaps = 32'h80200003;

    logic                   clk_i = 1'b0;
    logic                   rst_i;
    logic                   ext_irq_i;
    logic                   req_valid_i;
    logic                   req_write_i;
    logic [AddrWidth-1:0]   req_addr_i;
    logic [DataWidth-1:0]   req_wdata_i;
    logic                   resp_valid_o;
    logic                   resp_error_o;
    logic [DataWidth-1:0]   resp_rdata_o;
    logic [NumTargets-1:0]  irq_o;

    logic [31:0] lfsr_q    = LfsrSeed;
    int          cycle_cnt = 0;

    // --------------------
    // reference model state
    // --------------------
    logic                 m_en    [TimerCnt];
    logic                 m_pend  [TimerCnt];
    logic [DataWidth-1:0] m_count [TimerCnt];
    logic [DataWidth-1:0] m_cmp   [TimerCnt];
    logic [PrioWidth-1:0] m_prio  [NumSrc];
    logic [NumSrc-1:0]    m_ien   [NumTargets];
    logic [PrioWidth-1:0] m_thr   [NumTargets];
    logic                 m_ext;

    // response expected one cycle after the current request
    logic                 exp_valid;
    logic                 exp_error;
    logic [DataWidth-1:0] exp_rdata;

    periph_top #(
        .TimerCnt   ( TimerCnt   ),
        .NumTargets ( NumTargets )
    ) i_dut (
        .clk_i        ( clk_i        ),
        .rst_i        ( rst_i        ),
        .ext_irq_i    ( ext_irq_i    ),
        .req_valid_i  ( req_valid_i  ),
        .req_write_i  ( req_write_i  ),
        .req_addr_i   ( req_addr_i   ),
        .req_wdata_i  ( req_wdata_i  ),
        .resp_valid_o ( resp_valid_o ),
        .resp_error_o ( resp_error_o ),
        .resp_rdata_o ( resp_rdata_o ),
        .irq_o        ( irq_o        )
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MaxCycles) begin
            $display("timeout after %0d cycles, the stimulus never completed", cycle_cnt);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits = {bits[30:0], lfsr_q[0]};
            if (lfsr_q[0]) begin
                lfsr_q = (lfsr_q >> 1) ^ LfsrTaps;
            end else begin
                lfsr_q = lfsr_q >> 1;
            end
        end
        return bits;
    endfunction

    function automatic logic [NumSrc-1:0] src_levels(input logic ext);
        logic [NumSrc-1:0] lv;
        lv[0] = ext;
        for (int i = 0; i < TimerCnt; i++) begin
            lv[1+i] = m_pend[i];
        end
        return lv;
    endfunction

    function automatic logic [NumSrc-1:0] active_mask(input int t, input logic [NumSrc-1:0] lv);
        logic [NumSrc-1:0] mask;
        for (int s = 0; s < NumSrc; s++) begin
            mask[s] = lv[s] && m_ien[t][s] && (m_prio[s] > m_thr[t]);
        end
        return mask;
    endfunction

    // scan from the top priority down, lowest source first within a level
    function automatic int claim_of(input int t, input logic [NumSrc-1:0] lv);
        logic [NumSrc-1:0] mask;
        mask = active_mask(t, lv);
        for (int p = (1 << PrioWidth) - 1; p > 0; p--) begin
            for (int s = 0; s < NumSrc; s++) begin
                if (mask[s] && int'(m_prio[s]) == p) begin
                    return s + 1;
                end
            end
        end
        return 0;
    endfunction

    function automatic logic [DataWidth-1:0] timer_read(input logic [OffsetWidth-1:0] off);
        int idx;
        idx = int'(off[5:2]);
        if (idx >= TimerCnt) begin
            return '0;
        end
        case (timer_reg_e'(off[1:0]))
            TREG_CTRL:    return DataWidth'(m_en[idx]);
            TREG_COUNT:   return m_count[idx];
            TREG_COMPARE: return m_cmp[idx];
            default:      return DataWidth'(m_pend[idx]);
        endcase
    endfunction

    function automatic logic [DataWidth-1:0] irq_read(input logic [OffsetWidth-1:0] off,
                                                      input logic [NumSrc-1:0] lv);
        int w;
        w = int'(off);
        if (w < NumSrc) begin
            return DataWidth'(m_prio[w]);
        end
        for (int t = 0; t < NumTargets; t++) begin
            if (w == 8 + t) begin
                return DataWidth'(m_ien[t]);
            end
            if (w == 12 + t) begin
                return DataWidth'(m_thr[t]);
            end
            if (w == 16 + t) begin
                return DataWidth'(claim_of(t, lv));
            end
        end
        if (w == 20) begin
            return DataWidth'(lv);
        end
        return '0;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < TimerCnt; i++) begin
            m_en[i]    = 1'b0;
            m_pend[i]  = 1'b0;
            m_count[i] = '0;
            m_cmp[i]   = '0;
        end
        for (int s = 0; s < NumSrc; s++) begin
            m_prio[s] = '0;
        end
        for (int t = 0; t < NumTargets; t++) begin
            m_ien[t] = '0;
            m_thr[t] = '0;
        end
        m_ext     = 1'b0;
        exp_valid = 1'b0;
        exp_error = 1'b0;
        exp_rdata = '0;
    endtask

    // --------------------
    // model of one clock edge
    // --------------------
    task automatic predict_edge(input logic valid, input logic write, input logic [3:0] region,
                                input logic [OffsetWidth-1:0] off,
                                input logic [DataWidth-1:0] wdata);
        logic [NumSrc-1:0] lv;
        logic              wr_timer;
        logic              wr_irq;
        logic              hit;
        logic              match;
        timer_reg_e        treg;
        lv       = src_levels(m_ext);
        wr_timer = valid && write && (region == 4'd0);
        wr_irq   = valid && write && (region == 4'd1);
        treg     = timer_reg_e'(off[1:0]);

        // reads see the state from before this edge
        exp_valid = valid;
        exp_error = valid && (region > 4'd1);
        if (valid) begin
            if (region == 4'd0) begin
                exp_rdata = timer_read(off);
            end else if (region == 4'd1) begin
                exp_rdata = irq_read(off, lv);
            end else begin
                exp_rdata = StubRdata;
            end
        end

        for (int i = 0; i < TimerCnt; i++) begin
            hit   = wr_timer && (int'(off[5:2]) == i);
            match = m_en[i] && (m_count[i] == m_cmp[i]);
            if (hit && treg == TREG_COUNT) begin
                m_count[i] = wdata;
            end else if (match) begin
                m_count[i] = '0;
            end else if (m_en[i]) begin
                m_count[i] = m_count[i] + 32'd1;
            end
            if (match) begin
                m_pend[i] = 1'b1;
            end else if (hit && treg == TREG_STATUS && wdata[0]) begin
                m_pend[i] = 1'b0;
            end
            if (hit && treg == TREG_CTRL) begin
                m_en[i] = wdata[0];
            end
            if (hit && treg == TREG_COMPARE) begin
                m_cmp[i] = wdata;
            end
        end

        if (wr_irq) begin
            if (int'(off) < NumSrc) begin
                m_prio[int'(off)] = wdata[PrioWidth-1:0];
            end
            for (int t = 0; t < NumTargets; t++) begin
                if (int'(off) == 8 + t) begin
                    m_ien[t] = wdata[NumSrc-1:0];
                end
                if (int'(off) == 12 + t) begin
                    m_thr[t] = wdata[PrioWidth-1:0];
                end
            end
        end
    endtask

    task automatic drive_and_predict();
        logic                   valid;
        logic                   write;
        logic [2:0]             rsel;
        logic [3:0]             region;
        logic [OffsetWidth-1:0] off;
        logic [DataWidth-1:0]   wdata;
        valid = (rand_bits(2) != 0);
        write = (rand_bits(1) != 0);
        rsel  = 3'(rand_bits(3));
        if (rsel < 3'd3) begin
            region = 4'd0;
        end else if (rsel < 3'd6) begin
            region = 4'd1;
        end else if (rsel == 3'd6) begin
            region = 4'd2 + 4'(rand_bits(1));
        end else begin
            region = 4'd4 + 4'(rand_bits(3));
        end
        if (region == 4'd0) begin
            off = 6'(rand_bits(3));
            // now and then a hole in the timer window
            if (rand_bits(4) == 0) begin
                off = 6'(rand_bits(6));
            end
        end else begin
            off = 6'(rand_bits(5));
        end
        // small values keep compare periods short
        if (rand_bits(2) != 0) begin
            wdata = rand_bits(4);
        end else begin
            wdata = rand_bits(32);
        end
        if (rand_bits(4) == 0) begin
            m_ext = ~m_ext;
        end
        req_valid_i = valid;
        req_write_i = write;
        req_addr_i  = {region, off, 2'(rand_bits(2))};
        req_wdata_i = wdata;
        ext_irq_i   = m_ext;
        predict_edge(valid, write, region, off, wdata);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
        $display("Result: FAILED");
        $fatal(1, "mismatch");
    endtask

    task automatic check_outputs();
        logic [NumSrc-1:0] lv;
        logic              exp_irq;
        lv = src_levels(m_ext);
        assert (resp_valid_o == exp_valid)
            else report_mismatch("resp_valid_o", 32'(resp_valid_o), 32'(exp_valid));
        assert (resp_error_o == exp_error)
            else report_mismatch("resp_error_o", 32'(resp_error_o), 32'(exp_error));
        if (exp_valid) begin
            assert (resp_rdata_o == exp_rdata)
                else report_mismatch("resp_rdata_o", resp_rdata_o, exp_rdata);
        end
        for (int t = 0; t < NumTargets; t++) begin
            exp_irq = |active_mask(t, lv);
            assert (irq_o[t] == exp_irq)
                else report_mismatch($sformatf("irq_o[%0d]", t), 32'(irq_o[t]), 32'(exp_irq));
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rst_i       = 1'b1;
        ext_irq_i   = 1'b0;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        reset_model();
        repeat (ResetCycles) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        drive_and_predict();
        repeat (StimCycles) begin
            @(posedge clk_i);
            #1;
            check_outputs();
            drive_and_predict();
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* design/periph_top.sv */
// simple word bus without ready; source 0 is ext_irq_i, source 1+i is timer i
module periph_top #(
    parameter int TimerCnt   = 2,
    parameter int NumTargets = 2
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             ext_irq_i,
    input  logic                             req_valid_i,
    input  logic                             req_write_i,
    input  logic [periph_pkg::AddrWidth-1:0] req_addr_i,
    input  logic [periph_pkg::DataWidth-1:0] req_wdata_i,
    output logic                             resp_valid_o,
    output logic                             resp_error_o,
    output logic [periph_pkg::DataWidth-1:0] resp_rdata_o,
    output logic [NumTargets-1:0]            irq_o
);

    import periph_pkg::*;

    logic                   sel_timer;
    logic                   sel_irq;
    logic                   wr_en;
    region_e                region;
    logic [OffsetWidth-1:0] offset;
    logic [DataWidth-1:0]   timer_rdata;
    logic [DataWidth-1:0]   irq_rdata;
    logic [TimerCnt-1:0]    timer_irq;

    // --------------------
    // request side
    // --------------------
    reg_decode i_reg_decode (
        .req_valid_i ( req_valid_i ),
        .req_write_i ( req_write_i ),
        .req_addr_i  ( req_addr_i  ),
        .sel_timer_o ( sel_timer   ),
        .sel_irq_o   ( sel_irq     ),
        .wr_en_o     ( wr_en       ),
        .region_o    ( region      ),
        .offset_o    ( offset      )
    );

    // --------------------
    // register blocks
    // --------------------
    timer_bank #(
        .TimerCnt ( TimerCnt )
    ) i_timer_bank (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .sel_i       ( sel_timer   ),
        .wr_en_i     ( wr_en       ),
        .offset_i    ( offset      ),
        .wdata_i     ( req_wdata_i ),
        .rdata_o     ( timer_rdata ),
        .timer_irq_o ( timer_irq   )
    );

    irq_ctrl #(
        .TimerCnt   ( TimerCnt   ),
        .NumTargets ( NumTargets )
    ) i_irq_ctrl (
        .clk_i     ( clk_i                  ),
        .rst_i     ( rst_i                  ),
        .sel_i     ( sel_irq                ),
        .wr_en_i   ( wr_en                  ),
        .offset_i  ( offset                 ),
        .wdata_i   ( req_wdata_i            ),
        .sources_i ( {timer_irq, ext_irq_i} ),
        .rdata_o   ( irq_rdata              ),
        .irq_o     ( irq_o                  )
    );

    // --------------------
    // response side
    // --------------------
    resp_mux i_resp_mux (
        .clk_i         ( clk_i        ),
        .rst_i         ( rst_i        ),
        .req_valid_i   ( req_valid_i  ),
        .region_i      ( region       ),
        .timer_rdata_i ( timer_rdata  ),
        .irq_rdata_i   ( irq_rdata    ),
        .resp_valid_o  ( resp_valid_o ),
        .resp_error_o  ( resp_error_o ),
        .resp_rdata_o  ( resp_rdata_o )
    );

endmodule

/* design/resp_mux.sv */
// one response per request, always one cycle later; no back-pressure
module resp_mux (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             req_valid_i,
    input  periph_pkg::region_e              region_i,
    input  logic [periph_pkg::DataWidth-1:0] timer_rdata_i,
    input  logic [periph_pkg::DataWidth-1:0] irq_rdata_i,
    output logic                             resp_valid_o,
    output logic                             resp_error_o,
    output logic [periph_pkg::DataWidth-1:0] resp_rdata_o
);

    import periph_pkg::*;

    logic [DataWidth-1:0] rdata_d;
    logic                 error_d;

    // spi, eth and holes all land on the stub responder
    always_comb begin
        unique case (region_i)
            REGION_TIMER: begin
                rdata_d = timer_rdata_i;
                error_d = 1'b0;
            end
            REGION_IRQ: begin
                rdata_d = irq_rdata_i;
                error_d = 1'b0;
            end
            default: begin
                rdata_d = StubRdata;
                error_d = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            resp_valid_o <= 1'b0;
            resp_error_o <= 1'b0;
        end else begin
            resp_valid_o <= req_valid_i;
            resp_error_o <= req_valid_i && error_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            resp_rdata_o <= rdata_d;
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        resp_valid_o |-> $past(req_valid_i))
        else $error("response without a request");

endmodule

/* design/irq_ctrl.sv */
// level sources only; TimerCnt up to 7 and NumTargets up to 4 to fit the word map
module irq_ctrl #(
    parameter int TimerCnt   = 2,
    parameter int NumTargets = 2
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               sel_i,
    input  logic                               wr_en_i,
    input  logic [periph_pkg::OffsetWidth-1:0] offset_i,
    input  logic [periph_pkg::DataWidth-1:0]   wdata_i,
    input  logic [TimerCnt:0]                  sources_i,
    output logic [periph_pkg::DataWidth-1:0]   rdata_o,
    output logic [NumTargets-1:0]              irq_o
);

    import periph_pkg::*;

    localparam int NumSrc     = 1 + TimerCnt;
    localparam int ClaimWidth = $clog2(NumSrc + 1);

    // word map of the controller window
    localparam logic [OffsetWidth-1:0] EnableBase = 6'd8;
    localparam logic [OffsetWidth-1:0] ThreshBase = 6'd12;
    localparam logic [OffsetWidth-1:0] ClaimBase  = 6'd16;
    localparam logic [OffsetWidth-1:0] LevelWord  = 6'd20;

    logic [NumSrc-1:0][PrioWidth-1:0]     prio_q;
    logic [NumTargets-1:0][NumSrc-1:0]    en_q;
    logic [NumTargets-1:0][PrioWidth-1:0] thresh_q;

    logic [NumTargets-1:0][NumSrc-1:0]     active;
    logic [NumTargets-1:0][PrioWidth-1:0]  best_prio;
    logic [NumTargets-1:0][ClaimWidth-1:0] claim;

    // --------------------
    // config registers
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prio_q   <= '0;
            en_q     <= '0;
            thresh_q <= '0;
        end else if (sel_i && wr_en_i) begin
            for (int s = 0; s < NumSrc; s++) begin
                if (offset_i == OffsetWidth'(s)) begin
                    prio_q[s] <= wdata_i[PrioWidth-1:0];
                end
            end
            for (int t = 0; t < NumTargets; t++) begin
                if (offset_i == EnableBase + OffsetWidth'(t)) begin
                    en_q[t] <= wdata_i[NumSrc-1:0];
                end
                if (offset_i == ThreshBase + OffsetWidth'(t)) begin
                    thresh_q[t] <= wdata_i[PrioWidth-1:0];
                end
            end
        end
    end

    // --------------------
    // arbitration
    // --------------------
    // strict compare keeps the lowest source on equal priority
    always_comb begin
        for (int t = 0; t < NumTargets; t++) begin
            best_prio[t] = '0;
            claim[t]     = '0;
            for (int s = 0; s < NumSrc; s++) begin
                active[t][s] = sources_i[s] && en_q[t][s] && (prio_q[s] > thresh_q[t]);
                if (active[t][s] && prio_q[s] > best_prio[t]) begin
                    best_prio[t] = prio_q[s];
                    claim[t]     = ClaimWidth'(s + 1);
                end
            end
        end
    end

    for (genvar t = 0; t < NumTargets; t++) begin : gen_target
        assign irq_o[t] = |active[t];

        assert property (@(posedge clk_i) disable iff (rst_i)
            irq_o[t] == (claim[t] != '0))
            else $error("target %0d line and claim disagree", t);
    end

    // --------------------
    // read mux
    // --------------------
    always_comb begin
        rdata_o = '0;
        for (int s = 0; s < NumSrc; s++) begin
            if (offset_i == OffsetWidth'(s)) begin
                rdata_o = DataWidth'(prio_q[s]);
            end
        end
        for (int t = 0; t < NumTargets; t++) begin
            if (offset_i == EnableBase + OffsetWidth'(t)) begin
                rdata_o = DataWidth'(en_q[t]);
            end
            if (offset_i == ThreshBase + OffsetWidth'(t)) begin
                rdata_o = DataWidth'(thresh_q[t]);
            end
            if (offset_i == ClaimBase + OffsetWidth'(t)) begin
                rdata_o = DataWidth'(claim[t]);
            end
        end
        if (offset_i == LevelWord) begin
            rdata_o = DataWidth'(sources_i);
        end
    end

endmodule

/* design/timer_bank.sv */
// TimerCnt up to 16; ctrl keeps only the enable bit, status only the pending bit
module timer_bank #(
    parameter int TimerCnt = 2
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               sel_i,
    input  logic                               wr_en_i,
    input  logic [periph_pkg::OffsetWidth-1:0] offset_i,
    input  logic [periph_pkg::DataWidth-1:0]   wdata_i,
    output logic [periph_pkg::DataWidth-1:0]   rdata_o,
    output logic [TimerCnt-1:0]                timer_irq_o
);

    import periph_pkg::*;

    localparam int IdxWidth = OffsetWidth - 2;

    logic [IdxWidth-1:0] idx;
    timer_reg_e          treg;

    logic                 en_q      [TimerCnt];
    logic                 pending_q [TimerCnt];
    logic [DataWidth-1:0] count_q   [TimerCnt];
    logic [DataWidth-1:0] compare_q [TimerCnt];
    logic [TimerCnt-1:0]  wr_hit;

    assign idx  = offset_i[OffsetWidth-1:2];
    assign treg = timer_reg_e'(offset_i[1:0]);

    // --------------------
    // per timer state
    // --------------------
    for (genvar i = 0; i < TimerCnt; i++) begin : gen_timer
        logic match;

        assign wr_hit[i]      = sel_i && wr_en_i && (idx == IdxWidth'(i));
        assign match          = en_q[i] && (count_q[i] == compare_q[i]);
        assign timer_irq_o[i] = pending_q[i];

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                en_q[i]      <= 1'b0;
                pending_q[i] <= 1'b0;
                count_q[i]   <= '0;
                compare_q[i] <= '0;
            end else begin
                if (wr_hit[i] && treg == TREG_CTRL) begin
                    en_q[i] <= wdata_i[0];
                end
                if (wr_hit[i] && treg == TREG_COMPARE) begin
                    compare_q[i] <= wdata_i;
                end
                // a bus write to count overrides counting, but not the match
                if (wr_hit[i] && treg == TREG_COUNT) begin
                    count_q[i] <= wdata_i;
                end else if (match) begin
                    count_q[i] <= '0;
                end else if (en_q[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end
                // set beats clear
                if (match) begin
                    pending_q[i] <= 1'b1;
                end else if (wr_hit[i] && treg == TREG_STATUS && wdata_i[0]) begin
                    pending_q[i] <= 1'b0;
                end
            end
        end

        // once in range, a running untouched timer stays in range
        assert property (@(posedge clk_i) disable iff (rst_i)
            en_q[i] && !wr_hit[i] && (count_q[i] <= compare_q[i])
            |=> count_q[i] <= compare_q[i])
            else $error("timer %0d count passed compare", i);
    end

    // --------------------
    // read mux
    // --------------------
    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < TimerCnt; i++) begin
            if (idx == IdxWidth'(i)) begin
                unique case (treg)
                    TREG_CTRL:    rdata_o = DataWidth'(en_q[i]);
                    TREG_COUNT:   rdata_o = count_q[i];
                    TREG_COMPARE: rdata_o = compare_q[i];
                    TREG_STATUS:  rdata_o = DataWidth'(pending_q[i]);
                endcase
            end
        end
    end

endmodule

/* design/reg_decode.sv */
// purely combinational; address bits 1:0 are ignored, only word accesses exist
module reg_decode (
    input  logic                               req_valid_i,
    input  logic                               req_write_i,
    input  logic [periph_pkg::AddrWidth-1:0]   req_addr_i,
    output logic                               sel_timer_o,
    output logic                               sel_irq_o,
    output logic                               wr_en_o,
    output periph_pkg::region_e                region_o,
    output logic [periph_pkg::OffsetWidth-1:0] offset_o
);

    import periph_pkg::*;

    logic [3:0] region_raw;

    assign region_raw = req_addr_i[AddrWidth-1 -: 4];
    assign offset_o   = req_addr_i[2 +: OffsetWidth];
    assign wr_en_o    = req_valid_i && req_write_i;

    always_comb begin
        unique case (region_raw)
            4'd0:    region_o = REGION_TIMER;
            4'd1:    region_o = REGION_IRQ;
            4'd2:    region_o = REGION_SPI;
            4'd3:    region_o = REGION_ETH;
            default: region_o = REGION_NONE;
        endcase

        // selects only qualify real requests
        sel_timer_o = req_valid_i && (region_o == REGION_TIMER);
        sel_irq_o   = req_valid_i && (region_o == REGION_IRQ);

        // both block windows must never be driven at once
        assert (!(sel_timer_o && sel_irq_o))
            else $error("timer and irq windows selected together");
    end

endmodule

/* design/periph_pkg.sv */
// shared widths and encodings; region field is addr[11:8], word offset is addr[7:2]
package periph_pkg;

    // --------------------
    // bus widths
    // --------------------
    localparam int DataWidth   = 32;
    localparam int AddrWidth   = 12;
    localparam int OffsetWidth = 6;

    // priority and threshold width, max priority is 7
    localparam int PrioWidth = 3;

    // --------------------
    // address regions
    // --------------------
    // raw region values above 3 all collapse onto REGION_NONE
    typedef enum logic [3:0] {
        REGION_TIMER = 4'd0,
        REGION_IRQ   = 4'd1,
        REGION_SPI   = 4'd2,
        REGION_ETH   = 4'd3,
        REGION_NONE  = 4'hf
    } region_e;

    // --------------------
    // timer registers
    // --------------------
    // timer i owns words 4i to 4i+3
    typedef enum logic [1:0] {
        TREG_CTRL    = 2'd0,
        TREG_COUNT   = 2'd1,
        TREG_COMPARE = 2'd2,
        TREG_STATUS  = 2'd3
    } timer_reg_e;

    // read pattern of the error responder
    localparam logic [DataWidth-1:0] StubRdata = 32'hdeadbeef;

endpackage
